// ==== Makefile ====
# Verilator build and run of the cell buffer manager testbench.
# Override any variable on the command line, for example: make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_cell_buffer
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/buf_params.svh ====
//==============================
// Sizes of the shared cell pool.
// BUF_DEPTH must stay 2**PTR_W, since the free list wraps its pointers.
// CNT_W is one bit wider than a pointer so a count can reach BUF_DEPTH.
//==============================
`ifndef BUF_PARAMS_SVH
`define BUF_PARAMS_SVH

// Number of switch ports sharing the pool.
`define NUM_PORTS 7

// Width of a cell pointer.
`define PTR_W 4

// Number of cells in the pool.
`define BUF_DEPTH (1 << `PTR_W)

// Width of the use counters.
`define CNT_W (`PTR_W + 1)

`endif

// ==== common/buf_pkg.sv ====
//==============================
// Shared types of the cell buffer manager.
// Widths follow buf_params.svh.
//==============================
`include "buf_params.svh"

package buf_pkg;

    // One bit per switch port.
    typedef logic [`NUM_PORTS-1:0] port_vec_t;

    // A port number.
    typedef logic [$clog2(`NUM_PORTS)-1:0] port_idx_t;

    // A cell pointer into the shared pool.
    typedef logic [`PTR_W-1:0] cell_ptr_t;

    // A count of cells, able to hold BUF_DEPTH itself.
    typedef logic [`CNT_W-1:0] cell_cnt_t;

    // Threshold control. Bit 3 set selects a right shift, clear a left shift.
    // Bits 2 to 0 give the shift amount.
    typedef logic [3:0] alpha_t;

endpackage

// ==== common/cell_if.sv ====
//==============================
// Grant and return events between allocator, free list and resource manager.
// get and ret are one-hot or zero; at most one return per cycle.
// grant_ptr is the head of the free list and is valid while get is set.
//==============================
`timescale 1ns/1ps

interface cell_if;

    buf_pkg::port_vec_t get;
    buf_pkg::port_vec_t ret;
    buf_pkg::cell_ptr_t grant_ptr;
    buf_pkg::cell_ptr_t ret_ptr;
    buf_pkg::port_vec_t avail;

    // The allocator issues grants for ports that are still available.
    modport alloc (
        output get,
        input  avail
    );

    // The resource manager counts grants and returns per port.
    modport mgr (
        input  get,
        input  ret,
        output avail
    );

    // The free list hands out its head and takes returned pointers back.
    modport fl (
        input  get,
        input  ret,
        input  ret_ptr,
        output grant_ptr
    );

endinterface

// ==== dv/tb_cell_buffer.sv ====
//==============================
// Testbench for the cell buffer manager.
// A reference model tracks cell owners, the free FIFO and round-robin order.
// Table returns must name a cell that the port holds at that step.
//==============================
`timescale 1ns/1ps
`include "buf_params.svh"

module tb_cell_buffer;

    localparam int CLK_PERIOD = 100;
    localparam int SETTLE = 6;
    localparam int NUM_STEPS = 13;
    localparam int NUM_RAND = 8;
    localparam int WATCHDOG_CYCLES = (NUM_STEPS + NUM_RAND + 1) * 20;

    typedef struct packed {
        buf_pkg::port_vec_t req;
        buf_pkg::alpha_t    alpha;
        logic               ret_en;
        buf_pkg::port_idx_t ret_port;
        buf_pkg::cell_ptr_t ret_ptr;
        logic [3:0]         hold;
    } step_t;

    logic               clk = 1'b0;
    logic               rst;
    buf_pkg::alpha_t    alpha;
    buf_pkg::port_vec_t req;
    logic               ret_valid;
    buf_pkg::port_idx_t ret_port;
    buf_pkg::cell_ptr_t ret_ptr;
    buf_pkg::port_vec_t grant;
    buf_pkg::cell_ptr_t grant_ptr;
    buf_pkg::port_vec_t avail;

    // Reference model. owner holds the port of each cell, or -1 while it is free.
    buf_pkg::cell_ptr_t free_q [$];
    int                 owner [`BUF_DEPTH];
    int                 prio;
    int                 exp_port;
    buf_pkg::port_vec_t exp_grant;
    buf_pkg::port_vec_t model_avail;
    logic               pend_ret;
    buf_pkg::cell_ptr_t pend_ptr;
    int unsigned        seed = 1;
    step_t              steps [NUM_STEPS];

    cell_buffer_top cell_buffer_top_inst (
        .clk       (clk),
        .rst       (rst),
        .alpha     (alpha),
        .req       (req),
        .ret_valid (ret_valid),
        .ret_port  (ret_port),
        .ret_ptr   (ret_ptr),
        .grant     (grant),
        .grant_ptr (grant_ptr),
        .avail     (avail)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_ptr(input string name, input buf_pkg::cell_ptr_t got,
                             input buf_pkg::cell_ptr_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_ports(input string name, input buf_pkg::port_vec_t got,
                               input buf_pkg::port_vec_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic int unsigned lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 16;
    endfunction

    function automatic int held_count(input int p);
        int n;
        n = 0;
        for (int i = 0; i < `BUF_DEPTH; i++) begin
            if (owner[i] == p) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic buf_pkg::cell_ptr_t first_cell(input int p);
        for (int i = 0; i < `BUF_DEPTH; i++) begin
            if (owner[i] == p) begin
                return buf_pkg::cell_ptr_t'(i);
            end
        end
        return '0;
    endfunction

    // First requesting, available port at or after the priority pointer.
    function automatic buf_pkg::port_vec_t predict_grant(input buf_pkg::port_vec_t req_v);
        buf_pkg::port_vec_t elig;
        int idx;
        elig = req_v & model_avail;
        if (free_q.size() == 0) begin
            return '0;
        end
        for (int i = 0; i < `NUM_PORTS; i++) begin
            idx = (prio + i) % `NUM_PORTS;
            if (elig[idx]) begin
                exp_port = idx;
                return buf_pkg::port_vec_t'(1) << idx;
            end
        end
        return '0;
    endfunction

    // A port stays available while it holds no more than the free cells scaled by alpha.
    function automatic buf_pkg::port_vec_t expected_avail(input buf_pkg::alpha_t a);
        buf_pkg::port_vec_t v;
        int thr;
        if (a[3]) begin
            thr = free_q.size() >> a[2:0];
        end else begin
            thr = free_q.size() << a[2:0];
        end
        for (int p = 0; p < `NUM_PORTS; p++) begin
            v[p] = (held_count(p) <= thr);
        end
        return v;
    endfunction

    // One clock cycle. The grant seen here was decided at the edge just passed.
    task automatic run_cycle(input buf_pkg::port_vec_t req_v, input buf_pkg::alpha_t a,
                             input logic ret_v, input buf_pkg::port_idx_t rport,
                             input buf_pkg::cell_ptr_t rptr);
        @(negedge clk);
        check_ports("grant", grant, exp_grant);
        if (exp_grant != '0) begin
            check_ptr("grant_ptr", grant_ptr, free_q[0]);
            owner[free_q[0]] = exp_port;
            void'(free_q.pop_front());
            prio = (exp_port + 1) % `NUM_PORTS;
        end
        if (pend_ret) begin
            free_q.push_back(pend_ptr);
            owner[pend_ptr] = -1;
        end
        req       = req_v;
        alpha     = a;
        ret_valid = ret_v;
        ret_port  = rport;
        ret_ptr   = rptr;
        pend_ret  = ret_v;
        pend_ptr  = rptr;
        // A cell returned in this cycle can be granted one edge later at the earliest.
        exp_grant = predict_grant(req_v);
    endtask

    task automatic apply_step(input step_t s);
        if (s.ret_en && owner[s.ret_ptr] != int'(s.ret_port)) begin
            stop_with_error($sformatf("Step returns cell %0d, which port %0d does not hold",
                                      s.ret_ptr, s.ret_port));
        end
        for (int c = 0; c < int'(s.hold); c++) begin
            run_cycle(s.req, s.alpha, s.ret_en && (c == 0), s.ret_port, s.ret_ptr);
        end
        for (int c = 0; c < SETTLE; c++) begin
            run_cycle('0, s.alpha, 1'b0, '0, '0);
        end
        model_avail = expected_avail(s.alpha);
        check_ports("avail", avail, model_avail);
    endtask

    // Fields: req, alpha, return enable, return port, return pointer, cycles req is held.
    task automatic load_table();
        // Round-robin fill, then port 0 takes a large share under a loose threshold.
        steps[0]  = '{7'h7F, 4'd0,  1'b0, 3'd0, 4'd0,  4'd7};
        steps[1]  = '{7'h01, 4'd2,  1'b0, 3'd0, 4'd0,  4'd5};
        steps[2]  = '{7'h02, 4'd2,  1'b0, 3'd0, 4'd0,  4'd1};
        // Threshold sweep over left and right shifts.
        steps[3]  = '{7'h00, 4'd0,  1'b0, 3'd0, 4'd0,  4'd1};
        steps[4]  = '{7'h00, 4'd1,  1'b0, 3'd0, 4'd0,  4'd1};
        steps[5]  = '{7'h00, 4'd9,  1'b0, 3'd0, 4'd0,  4'd1};
        steps[6]  = '{7'h00, 4'd10, 1'b0, 3'd0, 4'd0,  4'd1};
        // Returns bring port 0 back under the threshold.
        steps[7]  = '{7'h00, 4'd0,  1'b1, 3'd0, 4'd7,  4'd1};
        steps[8]  = '{7'h00, 4'd0,  1'b1, 3'd0, 4'd9,  4'd1};
        steps[9]  = '{7'h00, 4'd0,  1'b1, 3'd6, 4'd6,  4'd1};
        // Drain the pool, then hold requests against an empty free list.
        steps[10] = '{7'h3C, 4'd2,  1'b0, 3'd0, 4'd0,  4'd6};
        steps[11] = '{7'h7F, 4'd2,  1'b0, 3'd0, 4'd0,  4'd4};
        steps[12] = '{7'h7F, 4'd2,  1'b1, 3'd2, 4'd13, 4'd4};
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the test did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        int    p;
        step_t s;
        rst       = 1'b1;
        req       = '0;
        alpha     = '0;
        ret_valid = 1'b0;
        ret_port  = '0;
        ret_ptr   = '0;
        for (int i = 0; i < `BUF_DEPTH; i++) begin
            free_q.push_back(buf_pkg::cell_ptr_t'(i));
            owner[i] = -1;
        end
        prio        = 0;
        exp_port    = 0;
        exp_grant   = '0;
        model_avail = '1;
        pend_ret    = 1'b0;
        pend_ptr    = '0;
        load_table();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        check_ports("avail", avail, '1);
        for (int i = 0; i < NUM_STEPS; i++) begin
            apply_step(steps[i]);
        end
        // Random returns from random holders with random alpha.
        for (int n = 0; n < NUM_RAND; n++) begin
            p = int'(lcg_next() % `NUM_PORTS);
            while (held_count(p) == 0) begin
                p = (p + 1) % `NUM_PORTS;
            end
            s.req      = '0;
            s.alpha    = buf_pkg::alpha_t'(lcg_next());
            s.ret_en   = 1'b1;
            s.ret_port = buf_pkg::port_idx_t'(p);
            s.ret_ptr  = first_cell(p);
            s.hold     = 4'd1;
            apply_step(s);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== free_list/free_list.sv ====
//==============================
// Circular FIFO of free cell pointers, full with 0 to 15 after reset.
// The head is popped at the edge that ends a grant pulse.
// empty also covers the last cell while its grant is still pending.
//==============================
`timescale 1ns/1ps
`include "buf_params.svh"

module free_list (
    input  logic clk,
    input  logic rst,
    output logic empty,
    cell_if.fl   cells
);

    buf_pkg::cell_ptr_t mem [`BUF_DEPTH];
    buf_pkg::cell_ptr_t head;
    buf_pkg::cell_ptr_t tail;
    buf_pkg::cell_cnt_t count;
    logic               pop;
    logic               push;

    assign pop  = |cells.get;
    assign push = |cells.ret;

    // The granted pointer is the head until the grant pulse ends.
    assign cells.grant_ptr = mem[head];

    // A pending pop already claims the head, so one cell left counts as none.
    assign empty = (count == '0) || (count == buf_pkg::cell_cnt_t'(1) && pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BUF_DEPTH; i++) begin
                mem[i] <= buf_pkg::cell_ptr_t'(i);
            end
        end else if (push) begin
            mem[tail] <= cells.ret_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= buf_pkg::cell_cnt_t'(`BUF_DEPTH);
        end else begin
            if (pop) begin
                head <= head + 1'b1;
            end
            if (push) begin
                tail <= tail + 1'b1;
            end
            case ({pop, push})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The allocator must hold back while the list is empty.
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> (count != '0))
        else $error("grant issued with an empty free list");

    // A return while full means a cell came back that was never handed out.
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push |-> (count != buf_pkg::cell_cnt_t'(`BUF_DEPTH) || pop))
        else $error("return pushed into a full free list");

endmodule

// ==== hdl/cell_allocator.sv ====
//==============================
// Round-robin grant of one cell per cycle.
// Only ports with req and avail both high compete.
// No grant is made while the free list reports empty.
//==============================
`timescale 1ns/1ps
`include "buf_params.svh"

module cell_allocator (
    input  logic               clk,
    input  logic               rst,
    input  buf_pkg::port_vec_t req,
    input  logic               empty,
    cell_if.alloc              cells
);

    buf_pkg::port_vec_t eligible;
    buf_pkg::port_idx_t prio;
    buf_pkg::port_idx_t winner;
    logic               found;

    assign eligible = req & cells.avail;

    // First eligible port at or after the priority pointer, with wrap.
    always_comb begin
        int idx;
        winner = '0;
        found  = 1'b0;
        for (int i = 0; i < `NUM_PORTS; i++) begin
            idx = (int'(prio) + i) % `NUM_PORTS;
            if (!found && eligible[idx]) begin
                winner = buf_pkg::port_idx_t'(idx);
                found  = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cells.get <= '0;
            prio      <= '0;
        end else if (found && !empty) begin
            cells.get <= buf_pkg::port_vec_t'(1) << winner;
            // Next search starts just past the port served now.
            if (winner == buf_pkg::port_idx_t'(`NUM_PORTS - 1)) begin
                prio <= '0;
            end else begin
                prio <= winner + 1'b1;
            end
        end else begin
            cells.get <= '0;
        end
    end

    // A port just served yields the next grant to any other eligible port.
    for (genvar g = 0; g < `NUM_PORTS; g++) begin : g_fair
        a_rr_yield: assert property (@(posedge clk) disable iff (rst)
            (cells.get[g] && !empty
             && ((eligible & ~(buf_pkg::port_vec_t'(1) << g)) != '0))
            |=> !cells.get[g])
            else $error("port %0d served twice while another port waited", g);
    end

endmodule

// ==== hdl/cell_buffer_top.sv ====
//==============================
// Cell buffer manager top level.
// ret_ptr must name a cell that ret_port currently holds.
//==============================
`timescale 1ns/1ps

module cell_buffer_top (
    input  logic               clk,
    input  logic               rst,
    input  buf_pkg::alpha_t    alpha,
    input  buf_pkg::port_vec_t req,
    input  logic               ret_valid,
    input  buf_pkg::port_idx_t ret_port,
    input  buf_pkg::cell_ptr_t ret_ptr,
    output buf_pkg::port_vec_t grant,
    output buf_pkg::cell_ptr_t grant_ptr,
    output buf_pkg::port_vec_t avail
);

    logic fl_empty;

    cell_if cells ();

    // One-hot return vector from the port number.
    assign cells.ret     = ret_valid ? (buf_pkg::port_vec_t'(1) << ret_port) : '0;
    assign cells.ret_ptr = ret_ptr;

    assign grant     = cells.get;
    assign grant_ptr = cells.grant_ptr;
    assign avail     = cells.avail;

    free_list free_list_inst (
        .clk   (clk),
        .rst   (rst),
        .empty (fl_empty),
        .cells (cells.fl)
    );

    cell_allocator cell_allocator_inst (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .empty (fl_empty),
        .cells (cells.alloc)
    );

    resource_manager resource_manager_inst (
        .clk   (clk),
        .rst   (rst),
        .alpha (alpha),
        .cells (cells.mgr)
    );

endmodule

// ==== resource_manager/resource_manager.sv ====
//==============================
// Per-port and total cell counts with a dynamic sharing threshold.
// avail lags a grant or a return by up to 4 clock edges.
// The threshold saturates at BUF_DEPTH, which no count can exceed.
//==============================
`timescale 1ns/1ps
`include "buf_params.svh"

module resource_manager (
    input  logic               clk,
    input  logic               rst,
    input  buf_pkg::alpha_t    alpha,
    cell_if.mgr                cells
);

    // Wide enough for the free count shifted left by up to 7.
    localparam int SHIFT_W = `CNT_W + 7;

    buf_pkg::port_vec_t get_d1;
    buf_pkg::port_vec_t ret_d1;
    buf_pkg::cell_cnt_t total_cnt;
    buf_pkg::cell_cnt_t port_cnt [`NUM_PORTS];
    buf_pkg::cell_cnt_t threshold;
    buf_pkg::cell_cnt_t free_cells;
    buf_pkg::cell_cnt_t threshold_next;
    logic [SHIFT_W-1:0] shift_wide;

    // Grant and return events are registered once before they reach the counters.
    always_ff @(posedge clk) begin
        if (rst) begin
            get_d1 <= '0;
            ret_d1 <= '0;
        end else begin
            get_d1 <= cells.get;
            ret_d1 <= cells.ret;
        end
    end

    // Total count moves on any grant or return, and holds when both happen.
    always_ff @(posedge clk) begin
        if (rst) begin
            total_cnt <= '0;
        end else begin
            case ({|get_d1, |ret_d1})
                2'b10:   total_cnt <= total_cnt + 1'b1;
                2'b01:   total_cnt <= total_cnt - 1'b1;
                default: total_cnt <= total_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_PORTS; i++) begin
                port_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_PORTS; i++) begin
                case ({get_d1[i], ret_d1[i]})
                    2'b10:   port_cnt[i] <= port_cnt[i] + 1'b1;
                    2'b01:   port_cnt[i] <= port_cnt[i] - 1'b1;
                    default: port_cnt[i] <= port_cnt[i];
                endcase
            end
        end
    end

    // Free cells scaled by alpha. Left shifts may exceed the pool size,
    // so the result is clamped to BUF_DEPTH before it is stored.
    always_comb begin
        free_cells = buf_pkg::cell_cnt_t'(`BUF_DEPTH) - total_cnt;
        if (alpha[3]) begin
            shift_wide = SHIFT_W'(free_cells) >> alpha[2:0];
        end else begin
            shift_wide = SHIFT_W'(free_cells) << alpha[2:0];
        end
        if (shift_wide > SHIFT_W'(`BUF_DEPTH)) begin
            threshold_next = buf_pkg::cell_cnt_t'(`BUF_DEPTH);
        end else begin
            threshold_next = buf_pkg::cell_cnt_t'(shift_wide);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            threshold   <= '0;
            cells.avail <= '1;
        end else begin
            threshold <= threshold_next;
            for (int i = 0; i < `NUM_PORTS; i++) begin
                cells.avail[i] <= !(port_cnt[i] > threshold);
            end
        end
    end

    // A port only returns cells it was granted earlier.
    for (genvar g = 0; g < `NUM_PORTS; g++) begin : g_underflow
        a_no_underflow: assert property (@(posedge clk) disable iff (rst)
            (ret_d1[g] && !get_d1[g]) |-> (port_cnt[g] != '0))
            else $error("port %0d count underflow", g);
    end

endmodule

// ==== vlog.f ====
+incdir+common
common/buf_pkg.sv
common/cell_if.sv
free_list/free_list.sv
resource_manager/resource_manager.sv
hdl/cell_allocator.sv
hdl/cell_buffer_top.sv
dv/tb_cell_buffer.sv
